// ==== logic/mgr_settings.svh ====
// -------------------------------------------------------------------------
// Manager widths, depths and credits
// -------------------------------------------------------------------------
`ifndef MGR_SETTINGS_SVH
`define MGR_SETTINGS_SVH

// Work-unit side
`define MGR_WU_ADDR_W    8    // Instruction address
`define MGR_WU_DEPTH     256  // Instruction words
`define MGR_TAG_W        4
`define MGR_LANE_W       6    // Lane count field
`define MGR_CMD_W        8    // Streaming-op and SIMD commands
`define MGR_MEM_ADDR_W   16

// Stack bus
`define MGR_DATA_W       32   // One lane word
`define MGR_OOB_DATA_W   16

// Flow control
`define MGR_OOB_CREDITS  2    // Downstream OOB beats in flight
`define MGR_UP_DEPTH     4    // Upstream FIFO, also stack start credits
`define MGR_WR_CREDITS   2    // Memory writes in flight
`define MGR_DESC_DEPTH   4

`endif

// ==== logic/mgr_wu_pkg.sv ====
// -------------------------------------------------------------------------
// Work-unit types
// -------------------------------------------------------------------------
`include "mgr_settings.svh"

package mgr_wu_pkg;

  typedef logic [`MGR_WU_ADDR_W-1:0]  wu_addr_t;
  typedef logic [`MGR_TAG_W-1:0]      tag_t;
  typedef logic [`MGR_LANE_W-1:0]     lane_cnt_t;
  typedef logic [`MGR_CMD_W-1:0]      cmd_t;       // Streaming-op or SIMD
  typedef logic [`MGR_MEM_ADDR_W-1:0] mem_addr_t;

  typedef enum logic [1:0] {
    NOP = 2'b00,
    OP  = 2'b01
  } wu_op_e;

  // One instruction word, 44 bits
  typedef struct packed {
    wu_op_e    op;
    tag_t      tag;
    lane_cnt_t num_lanes;
    cmd_t      stop_cmd;
    cmd_t      simd_cmd;
    mem_addr_t base_addr;
  } wu_inst_t;

  // Stack configuration, goes out on OOB
  typedef struct packed {
    tag_t      tag;
    lane_cnt_t num_lanes;
    cmd_t      stop_cmd;
    cmd_t      simd_cmd;
  } oob_cmd_t;

  // Where a tagged return packet lands
  typedef struct packed {
    tag_t      tag;
    mem_addr_t base_addr;
  } rdp_desc_t;

endpackage

// ==== logic/mgr_stack_pkg.sv ====
// -------------------------------------------------------------------------
// Stack bus types
// -------------------------------------------------------------------------
`include "mgr_settings.svh"

package mgr_stack_pkg;

  import mgr_wu_pkg::tag_t;
  import mgr_wu_pkg::mem_addr_t;

  typedef logic [`MGR_DATA_W-1:0]     lane_data_t;
  typedef logic [`MGR_OOB_DATA_W-1:0] oob_data_t;

  // Packet delineation
  typedef enum logic [1:0] {
    SOM     = 2'b01,
    MOM     = 2'b00,
    EOM     = 2'b10,
    SOM_EOM = 2'b11  // Single-beat packet
  } pkt_cntl_e;

  typedef enum logic {
    OOB_TAG_LANES = 1'b0,
    OOB_COMMANDS  = 1'b1
  } oob_type_e;

  typedef struct packed {
    pkt_cntl_e cntl;
    oob_type_e oob_type;
    oob_data_t data;
  } oob_beat_t;

  typedef struct packed {
    pkt_cntl_e  cntl;
    tag_t       tag;
    lane_data_t data;
  } up_beat_t;

  typedef struct packed {
    mem_addr_t  addr;
    lane_data_t data;
  } wr_req_t;

endpackage

// ==== logic/wu_memory.sv ====
// -------------------------------------------------------------------------
// Work-unit instruction memory
// -------------------------------------------------------------------------
`include "mgr_settings.svh"

module wu_memory (
  input  logic                 clk,
  input  logic                 rst_n,
  // Host load port
  input  logic                 prog_valid,
  input  mgr_wu_pkg::wu_addr_t prog_addr,
  input  mgr_wu_pkg::wu_inst_t prog_inst,
  // Fetch side
  input  logic                 rd_en,
  input  mgr_wu_pkg::wu_addr_t rd_addr,
  output logic                 rd_ready,
  // Decode side
  output logic                 inst_valid,
  output mgr_wu_pkg::wu_inst_t inst,
  input  logic                 inst_ready
);
  import mgr_wu_pkg::*;

  wu_inst_t mem [`MGR_WU_DEPTH];

  assign rd_ready = !inst_valid || inst_ready;  // Output reg empty or draining

  always_ff @(posedge clk) begin
    if (prog_valid) begin
      mem[prog_addr] <= prog_inst;
    end
  end

  // Output register, holds under back-pressure
  always_ff @(posedge clk) begin
    if (rd_en && rd_ready) begin
      inst <= mem[rd_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inst_valid <= 1'b0;
    end else if (rd_en && rd_ready) begin
      inst_valid <= 1'b1;
    end else if (inst_ready) begin
      inst_valid <= 1'b0;
    end
  end

  // Fetch only reads into a free slot
  assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> rd_ready);

endmodule

// ==== logic/wu_fetch.sv ====
// -------------------------------------------------------------------------
// Work-unit fetch
// -------------------------------------------------------------------------
module wu_fetch (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  mgr_wu_pkg::wu_addr_t start_addr,
  input  mgr_wu_pkg::wu_addr_t wu_len,
  input  logic                 rd_ready,
  output logic                 rd_en,
  output mgr_wu_pkg::wu_addr_t rd_addr,
  input  logic                 inst_taken,  // Decoder consumed one
  output logic                 busy
);
  import mgr_wu_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    DRAIN  // All reads issued, waiting on decode
  } fetch_state_e;

  fetch_state_e state;
  wu_addr_t     remain;      // Reads left to issue
  wu_addr_t     len_q;
  wu_addr_t     taken_cnt;
  wu_addr_t     taken_next;

  assign rd_en      = (state == FETCH) && rd_ready;
  assign busy       = (state != IDLE);
  assign taken_next = taken_cnt + wu_addr_t'(inst_taken);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= IDLE;
      rd_addr   <= '0;
      remain    <= '0;
      len_q     <= '0;
      taken_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            rd_addr   <= start_addr;
            remain    <= wu_len;
            len_q     <= wu_len;
            taken_cnt <= '0;
            state     <= (wu_len == '0) ? DRAIN : FETCH;  // Empty run just drains
          end
        end
        FETCH: begin
          taken_cnt <= taken_next;
          if (rd_en) begin
            rd_addr <= rd_addr + 1'b1;
            remain  <= remain - 1'b1;
            if (remain == wu_addr_t'(1)) begin
              state <= DRAIN;  // Last read out
            end
          end
        end
        DRAIN: begin
          taken_cnt <= taken_next;
          if (taken_next == len_q) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Host waits for busy low before the next run
  assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy);

endmodule

// ==== logic/wu_decode.sv ====
// -------------------------------------------------------------------------
// Work-unit decode and fork
// -------------------------------------------------------------------------
module wu_decode (
  input  logic                  clk,
  input  logic                  rst_n,
  // From instruction memory
  input  logic                  inst_valid,
  input  mgr_wu_pkg::wu_inst_t  inst,
  output logic                  inst_ready,
  // Configuration path
  output logic                  cmd_valid,
  output mgr_wu_pkg::oob_cmd_t  cmd,
  input  logic                  cmd_ready,
  // Descriptor path
  output logic                  desc_valid,
  output mgr_wu_pkg::rdp_desc_t desc,
  input  logic                  desc_ready
);
  import mgr_wu_pkg::*;

  logic take;
  logic is_op;

  // Both branches must be free so an OP forks in one go
  assign inst_ready = (!cmd_valid || cmd_ready) && (!desc_valid || desc_ready);
  assign take       = inst_valid && inst_ready;
  assign is_op      = (inst.op == OP);  // Anything else is dropped

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cmd_valid  <= 1'b0;
      desc_valid <= 1'b0;
    end else begin
      // Each side drains on its own ready
      if (take && is_op) begin
        cmd_valid <= 1'b1;
      end else if (cmd_ready) begin
        cmd_valid <= 1'b0;
      end
      if (take && is_op) begin
        desc_valid <= 1'b1;
      end else if (desc_ready) begin
        desc_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take && is_op) begin
      cmd <= '{tag:       inst.tag,
               num_lanes: inst.num_lanes,
               stop_cmd:  inst.stop_cmd,
               simd_cmd:  inst.simd_cmd};
      desc <= '{tag: inst.tag, base_addr: inst.base_addr};
    end
  end

endmodule

// ==== logic/oob_downstream_tx.sv ====
// -------------------------------------------------------------------------
// OOB downstream transmitter
// -------------------------------------------------------------------------
`include "mgr_settings.svh"

module oob_downstream_tx (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     cmd_valid,
  input  mgr_wu_pkg::oob_cmd_t     cmd,
  output logic                     cmd_ready,
  output logic                     oob_valid,
  output mgr_stack_pkg::oob_beat_t oob_beat,
  input  logic                     oob_credit
);
  import mgr_wu_pkg::*;
  import mgr_stack_pkg::*;

  localparam int CNT_W = $clog2(`MGR_OOB_CREDITS + 1);
  localparam int PAD_W = `MGR_OOB_DATA_W - `MGR_LANE_W - `MGR_TAG_W;

  typedef enum logic [1:0] {
    IDLE,
    BEAT0,  // Tag and lanes
    BEAT1   // Commands
  } tx_state_e;

  tx_state_e        state;
  logic [CNT_W-1:0] credit_cnt;
  oob_cmd_t         cmd_q;

  // Credit arriving this cycle may be spent at once
  assign oob_valid = (state != IDLE) && ((credit_cnt != '0) || oob_credit);
  assign cmd_ready = (state == IDLE) || ((state == BEAT1) && oob_valid);

  always_comb begin
    if (state == BEAT1) begin
      oob_beat.cntl     = EOM;
      oob_beat.oob_type = OOB_COMMANDS;
      oob_beat.data     = {cmd_q.stop_cmd, cmd_q.simd_cmd};
    end else begin
      oob_beat.cntl     = SOM;
      oob_beat.oob_type = OOB_TAG_LANES;
      oob_beat.data     = {{PAD_W{1'b0}}, cmd_q.num_lanes, cmd_q.tag};  // Zero-extended
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= IDLE;
      credit_cnt <= CNT_W'(`MGR_OOB_CREDITS);  // Stack capacity
    end else begin
      credit_cnt <= credit_cnt + CNT_W'(oob_credit) - CNT_W'(oob_valid);
      case (state)
        IDLE:  if (cmd_valid) state <= BEAT0;
        BEAT0: if (oob_valid) state <= BEAT1;
        BEAT1: if (oob_valid) state <= cmd_valid ? BEAT0 : IDLE;  // Back to back
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
      cmd_q <= cmd;
    end
  end

  // Stack never returns more than it was given
  assert property (@(posedge clk) disable iff (!rst_n)
    credit_cnt <= CNT_W'(`MGR_OOB_CREDITS));

endmodule

// ==== logic/stack_upstream_rx.sv ====
// -------------------------------------------------------------------------
// Stack upstream receiver
// -------------------------------------------------------------------------
`include "mgr_settings.svh"

module stack_upstream_rx (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    up_valid,
  input  mgr_stack_pkg::up_beat_t up_beat,
  output logic                    up_credit,
  output logic                    beat_valid,
  output mgr_stack_pkg::up_beat_t beat,
  input  logic                    beat_ready
);
  import mgr_stack_pkg::*;

  localparam int PTR_W = $clog2(`MGR_UP_DEPTH);
  localparam int CNT_W = $clog2(`MGR_UP_DEPTH + 1);

  up_beat_t         fifo [`MGR_UP_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  assign beat_valid = (count != '0);
  assign beat       = fifo[rd_ptr];  // Head always visible
  assign pop        = beat_valid && beat_ready;

  always_ff @(posedge clk) begin
    if (up_valid) begin
      fifo[wr_ptr] <= up_beat;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      up_credit <= 1'b0;
    end else begin
      if (up_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(`MGR_UP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`MGR_UP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count     <= count + CNT_W'(up_valid) - CNT_W'(pop);
      up_credit <= pop;  // Freed slot back to stack
    end
  end

  // Stack overran its credits
  assert property (@(posedge clk) disable iff (!rst_n)
    up_valid |-> (count != CNT_W'(`MGR_UP_DEPTH)));

endmodule

// ==== logic/return_data_proc.sv ====
// -------------------------------------------------------------------------
// Return data processor
// -------------------------------------------------------------------------
`include "mgr_settings.svh"

module return_data_proc (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    desc_valid,
  input  mgr_wu_pkg::rdp_desc_t   desc,
  output logic                    desc_ready,
  input  logic                    beat_valid,
  input  mgr_stack_pkg::up_beat_t beat,
  output logic                    beat_ready,
  output logic                    wr_valid,
  output mgr_stack_pkg::wr_req_t  wr_req,
  input  logic                    wr_credit,
  output logic                    tag_error   // Sticky
);
  import mgr_wu_pkg::*;
  import mgr_stack_pkg::*;

  localparam int DPTR_W = $clog2(`MGR_DESC_DEPTH);
  localparam int DCNT_W = $clog2(`MGR_DESC_DEPTH + 1);
  localparam int WCNT_W = $clog2(`MGR_WR_CREDITS + 1);

  typedef enum logic [1:0] {
    WAIT_SOM,
    WRITE,
    DISCARD  // Wrong tag, skip to EOM
  } rdp_state_e;

  // ------------------------------------------------------------------------
  // Descriptor queue
  rdp_desc_t         dq_mem [`MGR_DESC_DEPTH];
  logic [DPTR_W-1:0] dq_wr;
  logic [DPTR_W-1:0] dq_rd;
  logic [DCNT_W-1:0] dq_cnt;
  rdp_desc_t         head;
  logic              head_valid;
  logic              push;
  logic              retire;

  rdp_state_e        state;
  logic [WCNT_W-1:0] wr_cnt;
  mem_addr_t         offset;     // Beat index in packet
  logic              tag_match;
  logic              is_eom;
  logic              can_wr;

  assign head       = dq_mem[dq_rd];
  assign head_valid = (dq_cnt != '0);
  assign desc_ready = (dq_cnt != DCNT_W'(`MGR_DESC_DEPTH));
  assign push       = desc_valid && desc_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      dq_mem[dq_wr] <= desc;
    end
  end

  // ------------------------------------------------------------------------
  // Packet handling
  assign tag_match   = (beat.tag == head.tag);
  assign is_eom      = (beat.cntl == EOM) || (beat.cntl == SOM_EOM);
  assign can_wr      = (wr_cnt != '0) || wr_credit;
  assign wr_req.addr = head.base_addr + offset;
  assign wr_req.data = beat.data;
  assign retire      = wr_valid && is_eom;  // Descriptor done

  always_comb begin
    beat_ready = 1'b0;
    wr_valid   = 1'b0;
    case (state)
      WAIT_SOM: begin
        if (head_valid) begin  // Need a descriptor to compare against
          beat_ready = tag_match ? can_wr : 1'b1;
          wr_valid   = beat_valid && tag_match && can_wr;
        end
      end
      WRITE: begin
        beat_ready = can_wr;
        wr_valid   = beat_valid && can_wr;
      end
      DISCARD: beat_ready = 1'b1;
      default: beat_ready = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= WAIT_SOM;
      offset    <= '0;
      tag_error <= 1'b0;
      wr_cnt    <= WCNT_W'(`MGR_WR_CREDITS);
      dq_wr     <= '0;
      dq_rd     <= '0;
      dq_cnt    <= '0;
    end else begin
      wr_cnt <= wr_cnt + WCNT_W'(wr_credit) - WCNT_W'(wr_valid);
      dq_cnt <= dq_cnt + DCNT_W'(push) - DCNT_W'(retire);
      if (push) begin
        dq_wr <= (dq_wr == DPTR_W'(`MGR_DESC_DEPTH - 1)) ? '0 : dq_wr + 1'b1;
      end
      if (retire) begin
        dq_rd <= (dq_rd == DPTR_W'(`MGR_DESC_DEPTH - 1)) ? '0 : dq_rd + 1'b1;
      end
      if (wr_valid) begin
        offset <= is_eom ? '0 : offset + 1'b1;
      end
      case (state)
        WAIT_SOM: begin
          if (beat_valid && beat_ready && !is_eom) begin
            state <= tag_match ? WRITE : DISCARD;
          end
          if (beat_valid && beat_ready && !tag_match) begin
            tag_error <= 1'b1;
          end
        end
        WRITE:   if (retire) state <= WAIT_SOM;
        DISCARD: if (beat_valid && is_eom) state <= WAIT_SOM;
        default: state <= WAIT_SOM;
      endcase
    end
  end

  // Memory side returns no extra credits
  assert property (@(posedge clk) disable iff (!rst_n)
    wr_cnt <= WCNT_W'(`MGR_WR_CREDITS));

endmodule

// ==== logic/manager.sv ====
// -------------------------------------------------------------------------
// Work-unit manager top
// -------------------------------------------------------------------------
module manager (
  input  logic                     clk,
  input  logic                     rst_n,
  // Host load and control
  input  logic                     prog_valid,
  input  mgr_wu_pkg::wu_addr_t     prog_addr,
  input  mgr_wu_pkg::wu_inst_t     prog_inst,
  input  logic                     start,
  input  mgr_wu_pkg::wu_addr_t     start_addr,
  input  mgr_wu_pkg::wu_addr_t     wu_len,
  output logic                     busy,
  // Stack OOB downstream
  output logic                     oob_valid,
  output mgr_stack_pkg::oob_beat_t oob_beat,
  input  logic                     oob_credit,
  // Stack upstream
  input  logic                     up_valid,
  input  mgr_stack_pkg::up_beat_t  up_beat,
  output logic                     up_credit,
  // Memory writes
  output logic                     wr_valid,
  output mgr_stack_pkg::wr_req_t   wr_req,
  input  logic                     wr_credit,
  output logic                     tag_error
);
  import mgr_wu_pkg::*;
  import mgr_stack_pkg::*;

  // ------------------------------------------------------------------------
  // Pipeline links
  logic      rd_en;
  logic      rd_ready;
  wu_addr_t  rd_addr;
  logic      inst_valid;
  logic      inst_ready;
  wu_inst_t  inst;
  logic      cmd_valid;
  logic      cmd_ready;
  oob_cmd_t  cmd;
  logic      desc_valid;
  logic      desc_ready;
  rdp_desc_t desc;
  logic      beat_valid;
  logic      beat_ready;
  up_beat_t  beat;

  wu_fetch u_wu_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .start_addr (start_addr),
    .wu_len     (wu_len),
    .rd_ready   (rd_ready),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .inst_taken (inst_valid && inst_ready),  // Decode accept, NOPs included
    .busy       (busy)
  );

  wu_memory u_wu_memory (
    .clk        (clk),
    .rst_n      (rst_n),
    .prog_valid (prog_valid),
    .prog_addr  (prog_addr),
    .prog_inst  (prog_inst),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_ready   (rd_ready),
    .inst_valid (inst_valid),
    .inst       (inst),
    .inst_ready (inst_ready)
  );

  wu_decode u_wu_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .inst_ready (inst_ready),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_ready  (cmd_ready),
    .desc_valid (desc_valid),
    .desc       (desc),
    .desc_ready (desc_ready)
  );

  oob_downstream_tx u_oob_downstream_tx (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_ready  (cmd_ready),
    .oob_valid  (oob_valid),
    .oob_beat   (oob_beat),
    .oob_credit (oob_credit)
  );

  stack_upstream_rx u_stack_upstream_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .up_valid   (up_valid),
    .up_beat    (up_beat),
    .up_credit  (up_credit),
    .beat_valid (beat_valid),
    .beat       (beat),
    .beat_ready (beat_ready)
  );

  return_data_proc u_return_data_proc (
    .clk        (clk),
    .rst_n      (rst_n),
    .desc_valid (desc_valid),
    .desc       (desc),
    .desc_ready (desc_ready),
    .beat_valid (beat_valid),
    .beat       (beat),
    .beat_ready (beat_ready),
    .wr_valid   (wr_valid),
    .wr_req     (wr_req),
    .wr_credit  (wr_credit),
    .tag_error  (tag_error)
  );

endmodule

// ==== bench/tb_manager_checks.svh ====
// -------------------------------------------------------------------------
// Testbench compare tasks and reference queues
// -------------------------------------------------------------------------
`ifndef TB_MANAGER_CHECKS_SVH
`define TB_MANAGER_CHECKS_SVH

// ------------------------------------------------------------------------
// Reference model state
logic [31:0] rng = 32'hb437;  // xorshift state
oob_beat_t   exp_oob [$];     // OOB beats still to come, program order
wr_req_t     exp_wr [$];      // Writes still to come
rdp_desc_t   desc_q [$];      // Descriptors the DUT holds, oldest first

function automatic logic [31:0] xorshift(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic logic [31:0] rand32();
  rng = xorshift(rng);
  return rng;
endfunction

// ------------------------------------------------------------------------
// One compare per result kind
task automatic compare_oob(input string name, input oob_beat_t got, input oob_beat_t want);
  if (got !== want) begin
    report_failure($sformatf("FAILED %s got %h expected %h", name, got, want));
  end
endtask

task automatic compare_wr(input string name, input wr_req_t got, input wr_req_t want);
  if (got !== want) begin
    report_failure($sformatf("FAILED %s got %h expected %h", name, got, want));
  end
endtask

task automatic compare_bit(input string name, input logic got, input logic want);
  if (got !== want) begin
    report_failure($sformatf("FAILED %s got %h expected %h", name, got, want));
  end
endtask

// Counters and peaks
task automatic compare_count(input string name, input int got, input int want);
  if (got != want) begin
    report_failure($sformatf("FAILED %s got %h expected %h", name, got, want));
  end
endtask

`endif

// ==== bench/tb_manager.sv ====
// -------------------------------------------------------------------------
// Work-unit manager testbench
// -------------------------------------------------------------------------
`include "mgr_settings.svh"

module tb_manager;
  import mgr_wu_pkg::*;
  import mgr_stack_pkg::*;

  localparam int N_TESTS     = 5;
  localparam int QUIET_LIMIT = 150;  // Cycles for one run to drain

  logic      clk        = 1'b0;
  logic      rst_n;
  logic      prog_valid;
  wu_addr_t  prog_addr;
  wu_inst_t  prog_inst;
  logic      start;
  wu_addr_t  start_addr;
  wu_addr_t  wu_len;
  logic      busy;
  logic      oob_valid;
  oob_beat_t oob_beat;
  logic      oob_credit = 1'b0;  // Driven by the credit return process
  logic      up_valid;
  up_beat_t  up_beat;
  logic      up_credit;
  logic      wr_valid;
  wr_req_t   wr_req;
  logic      wr_credit  = 1'b0;
  logic      tag_error;

  // Flow bookkeeping, updated on the falling edge
  int   oob_outstanding = 0;
  int   oob_peak        = 0;
  int   wr_outstanding  = 0;
  int   up_credits      = `MGR_UP_DEPTH;  // Stack side starts full
  int   up_beats_sent   = 0;
  int   up_credit_cnt   = 0;
  int   oob_gap         = 0;  // Idle cycles between returned credits
  int   oob_wait        = 0;
  int   wr_gap          = 0;
  int   wr_wait         = 0;
  logic wr_hold         = 1'b0;  // Memory withholds credits

  `include "tb_manager_checks.svh"

  always #10 clk = ~clk;

  manager u_manager (
    .clk        (clk),
    .rst_n      (rst_n),
    .prog_valid (prog_valid),
    .prog_addr  (prog_addr),
    .prog_inst  (prog_inst),
    .start      (start),
    .start_addr (start_addr),
    .wu_len     (wu_len),
    .busy       (busy),
    .oob_valid  (oob_valid),
    .oob_beat   (oob_beat),
    .oob_credit (oob_credit),
    .up_valid   (up_valid),
    .up_beat    (up_beat),
    .up_credit  (up_credit),
    .wr_valid   (wr_valid),
    .wr_req     (wr_req),
    .wr_credit  (wr_credit),
    .tag_error  (tag_error)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "Run stopped at first error");
  endtask

  // ------------------------------------------------------------------------
  // Output monitor, mid-cycle when everything has settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (oob_valid) begin
        if (exp_oob.size() == 0) begin
          report_failure("OOB beat sent with no operation left to configure");
        end else begin
          compare_oob("oob_beat", oob_beat, exp_oob.pop_front());
        end
      end
      if (wr_valid) begin
        if (exp_wr.size() == 0) begin
          report_failure("Memory write issued with no matched beat pending");
        end else begin
          compare_wr("wr_req", wr_req, exp_wr.pop_front());
        end
      end
      oob_outstanding = oob_outstanding + int'(oob_valid) - int'(oob_credit);
      wr_outstanding  = wr_outstanding + int'(wr_valid) - int'(wr_credit);
      if (oob_outstanding > oob_peak) oob_peak = oob_outstanding;
      if (oob_outstanding > `MGR_OOB_CREDITS) begin
        report_failure("More OOB beats in flight than the stack has credits for");
      end
      if (wr_outstanding > `MGR_WR_CREDITS) begin
        report_failure("More writes in flight than the memory has credits for");
      end
      if (up_credit) begin
        up_credits    = up_credits + 1;
        up_credit_cnt = up_credit_cnt + 1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Stack and memory credit returns, one pulse per consumed beat
  always begin
    @(posedge clk);
    #2;
    oob_credit = 1'b0;
    if (oob_wait > 0) begin
      oob_wait = oob_wait - 1;
    end else if (oob_outstanding > 0) begin
      oob_credit = 1'b1;
      oob_wait   = oob_gap;
    end
  end

  always begin
    @(posedge clk);
    #2;
    wr_credit = 1'b0;
    if (wr_wait > 0) begin
      wr_wait = wr_wait - 1;
    end else if (wr_outstanding > 0 && !wr_hold) begin
      wr_credit = 1'b1;
      wr_wait   = wr_gap;
    end
  end

  // ------------------------------------------------------------------------
  // Stimulus helpers
  function automatic wu_inst_t random_inst(input wu_op_e op);
    wu_inst_t    w;
    logic [31:0] r0;
    logic [31:0] r1;
    r0          = rand32();
    r1          = rand32();
    w.op        = op;
    w.tag       = tag_t'(r0);
    w.num_lanes = lane_cnt_t'(r0 >> 4);
    w.stop_cmd  = cmd_t'(r0 >> 12);
    w.simd_cmd  = cmd_t'(r0 >> 20);
    w.base_addr = mem_addr_t'(r1);
    return w;
  endfunction

  // Two-beat config packet and one descriptor per OP
  task automatic expect_inst(input wu_inst_t w);
    oob_beat_t b;
    rdp_desc_t d;
    b.cntl     = SOM;
    b.oob_type = OOB_TAG_LANES;
    b.data     = oob_data_t'({w.num_lanes, w.tag});  // Zero-extended
    exp_oob.push_back(b);
    b.cntl     = EOM;
    b.oob_type = OOB_COMMANDS;
    b.data     = oob_data_t'({w.stop_cmd, w.simd_cmd});
    exp_oob.push_back(b);
    d.tag       = w.tag;
    d.base_addr = w.base_addr;
    desc_q.push_back(d);
  endtask

  task automatic load_inst(input wu_addr_t addr, input wu_inst_t word);
    @(posedge clk);
    #2;
    prog_valid = 1'b1;
    prog_addr  = addr;
    prog_inst  = word;
    @(posedge clk);
    #2;
    prog_valid = 1'b0;
  endtask

  // Bit i of op_mask set makes word i an OP
  task automatic load_and_start(input wu_addr_t base, input logic [7:0] op_mask,
                                input int len);
    wu_inst_t word;
    wu_op_e   op;
    for (int i = 0; i < len; i++) begin
      op   = op_mask[i] ? OP : NOP;
      word = random_inst(op);
      load_inst(base + wu_addr_t'(i), word);
      if (op == OP) expect_inst(word);
    end
    @(posedge clk);
    #2;
    start_addr = base;
    wu_len     = wu_addr_t'(len);
    start      = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
    @(negedge clk);
    compare_bit("busy", busy, 1'b1);  // Up the cycle after start
  endtask

  task automatic send_up_packet(input tag_t tag, input int n, input logic hit,
                                input mem_addr_t base);
    up_beat_t b;
    wr_req_t  w;
    int       i;
    for (i = 0; i < n; i++) begin
      @(posedge clk);
      #2;
      up_valid = 1'b0;
      while (up_credits == 0) begin  // Stack side waits for a free slot
        @(posedge clk);
        #2;
      end
      if (n == 1) b.cntl = SOM_EOM;
      else if (i == 0) b.cntl = SOM;
      else if (i == n - 1) b.cntl = EOM;
      else b.cntl = MOM;
      b.tag      = tag;
      b.data     = lane_data_t'(rand32());
      up_valid   = 1'b1;
      up_beat    = b;
      up_credits = up_credits - 1;
      up_beats_sent++;
      if (hit) begin
        w.addr = base + mem_addr_t'(i);  // Consecutive from base
        w.data = b.data;
        exp_wr.push_back(w);
      end
    end
    @(posedge clk);
    #2;
    up_valid = 1'b0;
  endtask

  // Idle run, nothing owed in either direction
  task automatic wait_quiet(input string what);
    int cycles;
    cycles = 0;
    while (exp_oob.size() != 0 || exp_wr.size() != 0 || oob_outstanding != 0 ||
           wr_outstanding != 0) begin
      @(posedge clk);
      #2;
      cycles++;
      if (cycles > QUIET_LIMIT) begin
        report_failure($sformatf("%s did not drain within %0d cycles", what, QUIET_LIMIT));
      end
    end
  endtask

  // ------------------------------------------------------------------------
  // Directed tests
  task automatic check_program_order();
    load_and_start(8'h10, 8'b0000_1010, 5);  // NOP OP NOP OP NOP
    wait_quiet("Mixed OP and NOP run");
    @(negedge clk);
    compare_bit("busy", busy, 1'b0);
  endtask

  task automatic throttle_oob_credits();
    oob_gap  = 8;
    oob_peak = 0;
    load_and_start(8'h40, 8'b0000_0101, 3);  // OP NOP OP
    wait_quiet("Credit-throttled run");
    compare_count("oob_outstanding_peak", oob_peak, `MGR_OOB_CREDITS);
    oob_gap = 0;
  endtask

  task automatic return_matched_packet();
    rdp_desc_t d;
    d = desc_q.pop_front();
    send_up_packet(d.tag, 3, 1'b1, d.base_addr);
    wait_quiet("Matched packet");
    @(negedge clk);
    compare_bit("tag_error", tag_error, 1'b0);
  endtask

  task automatic reject_wrong_tag();
    rdp_desc_t d;
    d = desc_q.pop_front();  // Kept by the DUT until a match
    send_up_packet(d.tag ^ tag_t'(1), 2, 1'b0, d.base_addr);
    wait_quiet("Discarded packet");
    @(negedge clk);
    compare_bit("tag_error", tag_error, 1'b1);
    send_up_packet(d.tag, 3, 1'b1, d.base_addr);
    wait_quiet("Packet after discard");
  endtask

  task automatic stall_write_credits();
    rdp_desc_t da;
    rdp_desc_t db;
    da      = desc_q.pop_front();
    db      = desc_q.pop_front();
    wr_hold = 1'b1;
    send_up_packet(da.tag, 4, 1'b1, da.base_addr);
    send_up_packet(db.tag, 2, 1'b1, db.base_addr);
    repeat (20) @(posedge clk);  // Let the stall settle
    @(negedge clk);
    compare_count("wr_outstanding", wr_outstanding, `MGR_WR_CREDITS);
    compare_count("pending_writes", exp_wr.size(), 4);
    wr_gap  = 2;  // Slow trickle after the stall
    wr_hold = 1'b0;
    wait_quiet("Write credit release");
    wr_gap = 0;
    compare_count("up_credit_pulses", up_credit_cnt, up_beats_sent);
  endtask

  // ------------------------------------------------------------------------
  // Watchdog and main sequence
  initial begin
    repeat (200 * N_TESTS) @(posedge clk);
    report_failure($sformatf("Simulation timed out after %0d cycles", 200 * N_TESTS));
  end

  initial begin
    rst_n      = 1'b0;
    prog_valid = 1'b0;
    prog_addr  = '0;
    prog_inst  = '0;
    start      = 1'b0;
    start_addr = '0;
    wu_len     = '0;
    up_valid   = 1'b0;
    up_beat    = '0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    compare_bit("oob_valid", oob_valid, 1'b0);
    compare_bit("up_credit", up_credit, 1'b0);
    compare_bit("wr_valid", wr_valid, 1'b0);
    compare_bit("busy", busy, 1'b0);
    compare_bit("tag_error", tag_error, 1'b0);
    check_program_order();
    throttle_oob_credits();
    return_matched_packet();
    reject_wrong_tag();
    stall_write_credits();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+logic
+incdir+bench
logic/mgr_wu_pkg.sv
logic/mgr_stack_pkg.sv
logic/wu_memory.sv
logic/wu_fetch.sv
logic/wu_decode.sv
logic/oob_downstream_tx.sv
logic/stack_upstream_rx.sv
logic/return_data_proc.sv
logic/manager.sv
bench/tb_manager.sv

// ==== Bender.yml ====
package:
  name: manager

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/mgr_wu_pkg.sv
      - logic/mgr_stack_pkg.sv
      - logic/wu_memory.sv
      - logic/wu_fetch.sv
      - logic/wu_decode.sv
      - logic/oob_downstream_tx.sv
      - logic/stack_upstream_rx.sv
      - logic/return_data_proc.sv
      - logic/manager.sv
  - target: test
    include_dirs:
      - logic
      - bench
    files:
      - bench/tb_manager.sv
